/* hdl/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ============================================================
// Fetch front end sizing
// ============================================================

`define XLEN          32           // Address and instruction word width
`define FETCH_WIDTH   4            // Slots per fetch group
`define RESOLVE_PORTS 2            // In-order resolve ports from the back end

// Predictor table, indexed by PC[BP_INDEX_W+1:2]
`define BP_ENTRIES    32
`define BP_INDEX_W    5

// First fetch address after reset
`define RESET_PC      32'h0000_0000

`endif

/* hdl/fetch_pkg.sv */
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

   typedef logic [`XLEN-1:0] addr_t;   // One word address
   typedef logic [`XLEN-1:0] instr_t;  // One raw instruction word

   // What pre-decode found in a slot
   typedef enum logic [1:0] {
      KIND_NONE   = 2'd0,
      KIND_BRANCH = 2'd1,  // Conditional branch, goes to the counters
      KIND_JAL    = 2'd2   // Always taken
   } slot_kind_e;

   // B-type layout, MSB first
   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } b_view_t;

   // J-type layout, MSB first
   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_view_t;

   // Same fetched word seen both ways, opcode picks the view
   typedef union packed {
      b_view_t b;
      j_view_t j;
      instr_t  raw;
   } rv_instr_u;

endpackage

`default_nettype wire

/* hdl/resolve_if.sv */
`default_nettype none

`include "fetch_cfg.svh"

// ============================================================
// Flush and predictor training traffic from the resolve side
// ============================================================
interface resolve_if import fetch_pkg::*; ();

   logic                        flush;      // Oldest misprediction this cycle
   addr_t                       flush_pc;   // Corrected PC of that report
   logic  [`RESOLVE_PORTS-1:0]  upd_en;     // Train this port's counter
   addr_t [`RESOLVE_PORTS-1:0]  upd_pc;     // Branch PC, selects the counter
   logic  [`RESOLVE_PORTS-1:0]  upd_taken;  // Resolved direction

   // Arbiter drives everything
   modport arb (
      output flush,
      output flush_pc,
      output upd_en,
      output upd_pc,
      output upd_taken
   );

   // PC steering only needs the redirect
   modport steer (
      input flush,
      input flush_pc
   );

   // Counter training side
   modport train (
      input upd_en,
      input upd_pc,
      input upd_taken
   );

endinterface

`default_nettype wire

/* hdl/resolve_arbiter.sv */
`default_nettype none

`include "fetch_cfg.svh"

module resolve_arbiter import fetch_pkg::*; (
   input  logic  [`RESOLVE_PORTS-1:0] resolve_valid_i,       // Report present
   input  logic  [`RESOLVE_PORTS-1:0] resolve_mispredict_i,  // Report is a mispredict
   input  logic  [`RESOLVE_PORTS-1:0] resolve_branch_i,      // Conditional branch
   input  logic  [`RESOLVE_PORTS-1:0] resolve_taken_i,       // Actual direction
   input  addr_t [`RESOLVE_PORTS-1:0] resolve_pc_i,          // PC of the branch
   input  addr_t [`RESOLVE_PORTS-1:0] resolve_target_i,      // Correct next PC
   resolve_if.arb                     rsl
);

   logic [`RESOLVE_PORTS-1:0] mis_vec;     // Valid mispredicting ports
   logic [`RESOLVE_PORTS-1:0] older_mis;   // Some lower port mispredicted
   logic                      mis_seen;    // Running OR while scanning

   // Port 0 is the oldest, so only a valid report can redirect
   assign mis_vec = resolve_valid_i & resolve_mispredict_i;

   // ============================================================
   // Oldest misprediction scan
   // ============================================================
   always_comb begin
      mis_seen     = 1'b0;
      older_mis    = '0;
      rsl.flush    = 1'b0;
      rsl.flush_pc = '0;
      for (int p = 0; p < `RESOLVE_PORTS; p++) begin
         older_mis[p] = mis_seen;          // Younger than a mispredict
         if (mis_vec[p] && !mis_seen) begin
            rsl.flush    = 1'b1;
            rsl.flush_pc = resolve_target_i[p];
         end
         mis_seen = mis_seen | mis_vec[p];
      end
   end

   // ============================================================
   // Training requests
   // ============================================================
   always_comb begin
      for (int p = 0; p < `RESOLVE_PORTS; p++) begin
         // The mispredicting port itself still trains, younger ones are wrong path
         rsl.upd_en[p]    = resolve_valid_i[p] & resolve_branch_i[p] & ~older_mis[p];
         rsl.upd_pc[p]    = rsl.upd_en[p] ? resolve_pc_i[p] : '0;
         rsl.upd_taken[p] = rsl.upd_en[p] & resolve_taken_i[p];
      end
   end

endmodule

`default_nettype wire

/* hdl/imm_predecode.sv */
`default_nettype none

`include "fetch_cfg.svh"

module imm_predecode import fetch_pkg::*; (
   input  instr_t     instr_i,   // Word returned for this slot
   output slot_kind_e kind_o,    // Branch, JAL or nothing of interest
   output addr_t      offset_o   // Sign-extended PC-relative offset
);

   // Major opcodes we care about
   localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
   localparam logic [6:0] OPC_JAL    = 7'b110_1111;

   rv_instr_u word;
   addr_t     b_off;
   addr_t     j_off;

   assign word = instr_i;

   // B offset is imm[12:1], bit 0 always zero
   assign b_off = {{(`XLEN-13){word.b.imm12}},
                   word.b.imm12,
                   word.b.imm11,
                   word.b.imm10_5,
                   word.b.imm4_1,
                   1'b0};

   // J offset is imm[20:1]
   assign j_off = {{(`XLEN-21){word.j.imm20}},
                   word.j.imm20,
                   word.j.imm19_12,
                   word.j.imm11,
                   word.j.imm10_1,
                   1'b0};

   always_comb begin
      // Both views share the opcode field
      case (word.b.opcode)
         OPC_BRANCH: begin
            kind_o   = KIND_BRANCH;
            offset_o = b_off;
         end
         OPC_JAL: begin
            kind_o   = KIND_JAL;
            offset_o = j_off;
         end
         default: begin
            kind_o   = KIND_NONE;   // ALU, load, JALR etc fall through
            offset_o = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* hdl/branch_predictor.sv */
`default_nettype none

`include "fetch_cfg.svh"

module branch_predictor import fetch_pkg::*; (
   input  logic                            clk,
   input  logic                            rst_i,
   input  addr_t                           fetch_pc_i,     // Slot 0 PC
   input  slot_kind_e [`FETCH_WIDTH-1:0]   kind_i,
   input  addr_t      [`FETCH_WIDTH-1:0]   offset_i,
   resolve_if.train                        rsl,
   output logic       [`FETCH_WIDTH-1:0]   pred_taken_o,
   output addr_t      [`FETCH_WIDTH-1:0]   pred_target_o
);

   logic [1:0] ctr_q [`BP_ENTRIES];   // 2-bit saturating counters

   addr_t [`FETCH_WIDTH-1:0] slot_pc;
   logic  [`BP_INDEX_W-1:0]  rd_idx [`FETCH_WIDTH];
   logic  [`BP_INDEX_W-1:0]  wr_idx [`RESOLVE_PORTS];

   // ============================================================
   // Lookup, one counter per slot
   // ============================================================
   always_comb begin
      for (int k = 0; k < `FETCH_WIDTH; k++) begin
         slot_pc[k] = fetch_pc_i + `XLEN'(4 * k);
         rd_idx[k]  = slot_pc[k][2 +: `BP_INDEX_W];   // Word aligned index
         // JAL always jumps, branch goes by the counter MSB
         pred_taken_o[k] = (kind_i[k] == KIND_JAL) |
                           ((kind_i[k] == KIND_BRANCH) & ctr_q[rd_idx[k]][1]);
         pred_target_o[k] = slot_pc[k] + offset_i[k];
      end
   end

   always_comb begin
      for (int p = 0; p < `RESOLVE_PORTS; p++) begin
         wr_idx[p] = rsl.upd_pc[p][2 +: `BP_INDEX_W];
      end
   end

   // ============================================================
   // Training
   // ============================================================
   // Walk from the youngest port down so port 0 lands last on a shared entry
   always_ff @(posedge clk) begin
      if (rst_i) begin
         for (int e = 0; e < `BP_ENTRIES; e++) begin
            ctr_q[e] <= 2'b01;                      // Weakly not taken
         end
      end else begin
         for (int p = `RESOLVE_PORTS - 1; p >= 0; p--) begin
            if (rsl.upd_en[p]) begin
               if (rsl.upd_taken[p]) begin
                  if (ctr_q[wr_idx[p]] != 2'b11) begin
                     ctr_q[wr_idx[p]] <= ctr_q[wr_idx[p]] + 2'd1;
                  end
               end else if (ctr_q[wr_idx[p]] != 2'b00) begin
                  ctr_q[wr_idx[p]] <= ctr_q[wr_idx[p]] - 2'd1;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/pc_steer.sv */
`default_nettype none

`include "fetch_cfg.svh"

module pc_steer import fetch_pkg::*; (
   input  logic                          clk,
   input  logic                          rst_i,
   input  logic                          stall_i,         // Bubble request
   input  logic                          fetch_ready_i,   // Buffer has room
   input  logic  [`FETCH_WIDTH-1:0]      pred_taken_i,
   input  addr_t [`FETCH_WIDTH-1:0]      pred_target_i,
   resolve_if.steer                      rsl,
   output addr_t                         fetch_pc_o,
   output logic  [`FETCH_WIDTH-1:0]      fetch_valid_o,
   output addr_t [`FETCH_WIDTH-1:0]      pc_o
);

   addr_t                    pc_q;
   addr_t                    pc_d;
   logic                     hold;           // Back-pressure or bubble
   logic                     base_valid;
   logic [`FETCH_WIDTH-1:0]  older_taken;    // A lower slot jumps away
   logic                     taken_seen;
   addr_t                    taken_target;   // Target of first taken slot

   assign hold       = stall_i | ~fetch_ready_i;
   assign base_valid = ~rsl.flush & ~hold & ~rst_i;
   assign fetch_pc_o = pc_q;

   // Slot PCs are consecutive words
   always_comb begin
      for (int k = 0; k < `FETCH_WIDTH; k++) begin
         pc_o[k] = pc_q + `XLEN'(4 * k);
      end
   end

   // ============================================================
   // First predicted-taken slot
   // ============================================================
   always_comb begin
      taken_seen   = 1'b0;
      taken_target = '0;
      older_taken  = '0;
      for (int k = 0; k < `FETCH_WIDTH; k++) begin
         older_taken[k] = taken_seen;
         if (pred_taken_i[k] && !taken_seen) begin
            taken_target = pred_target_i[k];
         end
         taken_seen = taken_seen | pred_taken_i[k];
      end
   end

   // Taken slot itself stays valid, everything after it is cut
   assign fetch_valid_o = {`FETCH_WIDTH{base_valid}} & ~older_taken;

   // Next PC, flush first
   always_comb begin
      if (rsl.flush) begin
         pc_d = rsl.flush_pc;
      end else if (hold) begin
         pc_d = pc_q;                               // Retry same group
      end else if (taken_seen) begin
         pc_d = taken_target;
      end else begin
         pc_d = pc_q + `XLEN'(4 * `FETCH_WIDTH);    // Sequential
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         pc_q <= `RESET_PC;
      end else begin
         pc_q <= pc_d;
      end
   end

endmodule

`default_nettype wire

/* hdl/fetch_top.sv */
`default_nettype none

`include "fetch_cfg.svh"

module fetch_top import fetch_pkg::*; (
   input  logic                          clk,
   input  logic                          rst_i,
   input  logic                          stall_i,
   input  logic                          fetch_ready_i,

   // Instruction memory, answers in the same cycle
   output addr_t  [`FETCH_WIDTH-1:0]     inst_addr_o,
   input  instr_t [`FETCH_WIDTH-1:0]     instr_i,

   // ============================================================
   // Resolve reports, port 0 oldest
   // ============================================================
   input  logic   [`RESOLVE_PORTS-1:0]   resolve_valid_i,
   input  logic   [`RESOLVE_PORTS-1:0]   resolve_mispredict_i,
   input  logic   [`RESOLVE_PORTS-1:0]   resolve_branch_i,
   input  logic   [`RESOLVE_PORTS-1:0]   resolve_taken_i,
   input  addr_t  [`RESOLVE_PORTS-1:0]   resolve_pc_i,
   input  addr_t  [`RESOLVE_PORTS-1:0]   resolve_target_i,

   // To the instruction buffer
   output logic   [`FETCH_WIDTH-1:0]     fetch_valid_o,
   output addr_t  [`FETCH_WIDTH-1:0]     pc_o,
   output logic   [`FETCH_WIDTH-1:0]     pred_taken_o
);

   resolve_if rsl ();

   slot_kind_e [`FETCH_WIDTH-1:0] slot_kind;
   addr_t      [`FETCH_WIDTH-1:0] slot_offset;
   logic       [`FETCH_WIDTH-1:0] pred_taken;
   addr_t      [`FETCH_WIDTH-1:0] pred_target;
   addr_t                         fetch_pc;
   addr_t      [`FETCH_WIDTH-1:0] slot_pc;

   assign inst_addr_o  = slot_pc;   // Same addresses go to memory and buffer
   assign pc_o         = slot_pc;
   assign pred_taken_o = pred_taken;

   resolve_arbiter u_arbiter (
      .resolve_valid_i      (resolve_valid_i),
      .resolve_mispredict_i (resolve_mispredict_i),
      .resolve_branch_i     (resolve_branch_i),
      .resolve_taken_i      (resolve_taken_i),
      .resolve_pc_i         (resolve_pc_i),
      .resolve_target_i     (resolve_target_i),
      .rsl                  (rsl.arb)
   );

   // One pre-decoder per slot
   for (genvar k = 0; k < `FETCH_WIDTH; k++) begin : g_predec
      imm_predecode u_predec (
         .instr_i  (instr_i[k]),
         .kind_o   (slot_kind[k]),
         .offset_o (slot_offset[k])
      );
   end

   branch_predictor u_bp (
      .clk           (clk),
      .rst_i         (rst_i),
      .fetch_pc_i    (fetch_pc),
      .kind_i        (slot_kind),
      .offset_i      (slot_offset),
      .rsl           (rsl.train),
      .pred_taken_o  (pred_taken),
      .pred_target_o (pred_target)
   );

   pc_steer u_steer (
      .clk           (clk),
      .rst_i         (rst_i),
      .stall_i       (stall_i),
      .fetch_ready_i (fetch_ready_i),
      .pred_taken_i  (pred_taken),
      .pred_target_i (pred_target),
      .rsl           (rsl.steer),
      .fetch_pc_o    (fetch_pc),
      .fetch_valid_o (fetch_valid_o),
      .pc_o          (slot_pc)
   );

endmodule

`default_nettype wire

/* bench/fetch_checker.sv */
`default_nettype none

`include "fetch_cfg.svh"

module fetch_checker import fetch_pkg::*; (
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic                      active_i,        // A cycle record is applied
   input  logic  [`FETCH_WIDTH-1:0]  exp_valid_i,
   input  addr_t                     exp_pc_i,        // Expected slot 0 PC
   input  logic  [`FETCH_WIDTH-1:0]  exp_pred_i,
   input  logic  [`FETCH_WIDTH-1:0]  fetch_valid_i,   // DUT outputs from here on
   input  addr_t [`FETCH_WIDTH-1:0]  pc_i,
   input  addr_t [`FETCH_WIDTH-1:0]  inst_addr_i,
   input  logic  [`FETCH_WIDTH-1:0]  pred_taken_i,
   output int                        err_count_o,
   output int                        check_count_o
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      err_count_o   = 0;
      check_count_o = 0;
   end

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      check_count_o++;
      if (actual !== expected) begin
         err_count_o++;
         $display("error at %0d ns: %s expected %h got %h", $time, name, expected, actual);
      end
   endtask

   // ============================================================
   // Compare mid-cycle, away from the drive edge
   // ============================================================
   always @(negedge clk_i) begin
      if (rst_i) begin
         compare_value("fetch_valid_o", '0, 32'(fetch_valid_i));   // Nothing valid in reset
      end else if (active_i) begin
         compare_value("fetch_valid_o", 32'(exp_valid_i), 32'(fetch_valid_i));
         compare_value("pred_taken_o", 32'(exp_pred_i), 32'(pred_taken_i));
         // Slot k sits 4k bytes above slot 0
         for (int k = 0; k < `FETCH_WIDTH; k++) begin
            compare_value($sformatf("pc_o[%0d]", k), exp_pc_i + `XLEN'(4 * k), pc_i[k]);
            compare_value($sformatf("inst_addr_o[%0d]", k), exp_pc_i + `XLEN'(4 * k),
                          inst_addr_i[k]);
         end
      end
   end

endmodule

`default_nettype wire

/* bench/tb_fetch_top.sv */
`default_nettype none

`include "fetch_cfg.svh"

module tb_fetch_top import fetch_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int     MAX_WORDS = 32;
   localparam int     MAX_RECS  = 64;
   localparam instr_t NOP       = 32'h0000_0013;   // addi x0, x0, 0

   logic                         clk = 1'b0;
   logic                         rst;
   logic                         stall;
   logic                         fetch_ready;
   addr_t  [`FETCH_WIDTH-1:0]    inst_addr;
   instr_t [`FETCH_WIDTH-1:0]    instr;
   logic   [`RESOLVE_PORTS-1:0]  resolve_valid;
   logic   [`RESOLVE_PORTS-1:0]  resolve_mispredict;
   logic   [`RESOLVE_PORTS-1:0]  resolve_branch;
   logic   [`RESOLVE_PORTS-1:0]  resolve_taken;
   addr_t  [`RESOLVE_PORTS-1:0]  resolve_pc;
   addr_t  [`RESOLVE_PORTS-1:0]  resolve_target;
   logic   [`FETCH_WIDTH-1:0]    fetch_valid;
   addr_t  [`FETCH_WIDTH-1:0]    pc;
   logic   [`FETCH_WIDTH-1:0]    pred_taken;

   logic                         active;      // Expected values below are live
   logic   [`FETCH_WIDTH-1:0]    exp_valid;
   addr_t                        exp_pc;      // Slot 0
   logic   [`FETCH_WIDTH-1:0]    exp_pred;
   int                           err_count;
   int                           check_count;

   addr_t       m_addr [MAX_WORDS];          // Sparse memory image
   instr_t      m_data [MAX_WORDS];
   int          m_count;
   logic [31:0] c_rec  [MAX_RECS][13];       // One row per cycle record
   int          c_count;
   int          cycle_count = 0;
   int          cycle_limit;
   bit          load_ok;

   always #5 clk = ~clk;   // 10 ns period

   fetch_top i_dut (
      .clk                  (clk),
      .rst_i                (rst),
      .stall_i              (stall),
      .fetch_ready_i        (fetch_ready),
      .inst_addr_o          (inst_addr),
      .instr_i              (instr),
      .resolve_valid_i      (resolve_valid),
      .resolve_mispredict_i (resolve_mispredict),
      .resolve_branch_i     (resolve_branch),
      .resolve_taken_i      (resolve_taken),
      .resolve_pc_i         (resolve_pc),
      .resolve_target_i     (resolve_target),
      .fetch_valid_o        (fetch_valid),
      .pc_o                 (pc),
      .pred_taken_o         (pred_taken)
   );

   fetch_checker u_checker (
      .clk_i         (clk),
      .rst_i         (rst),
      .active_i      (active),
      .exp_valid_i   (exp_valid),
      .exp_pc_i      (exp_pc),
      .exp_pred_i    (exp_pred),
      .fetch_valid_i (fetch_valid),
      .pc_i          (pc),
      .inst_addr_i   (inst_addr),
      .pred_taken_i  (pred_taken),
      .err_count_o   (err_count),
      .check_count_o (check_count)
   );

   // ============================================================
   // Instruction memory with a same-cycle answer
   // ============================================================
   function automatic instr_t read_word(addr_t addr);
      instr_t word;
      word = NOP;                                  // Unmapped word
      for (int i = 0; i < m_count; i++) begin
         if (m_addr[i] == addr) begin
            word = m_data[i];
         end
      end
      return word;
   endfunction

   always_comb begin
      for (int k = 0; k < `FETCH_WIDTH; k++) begin
         instr[k] = read_word(inst_addr[k]);
      end
   end

   // ============================================================
   // Golden file and stimulus
   // ============================================================
   task automatic load_golden();
      int    fd;
      int    n;
      string line;
      fd = $fopen("bench/golden_fetch.txt", "r");
      if (fd == 0) begin
         $display("could not open bench/golden_fetch.txt");
         load_ok = 1'b0;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n    = $fgets(line, fd);
         case (line.getc(0))
            "M": begin
               n = $sscanf(line, "M %h %h", m_addr[m_count], m_data[m_count]);
               if (n != 2 || m_count == MAX_WORDS) begin
                  $display("bad memory record in golden file: %s", line);
                  load_ok = 1'b0;
               end else begin
                  m_count++;
               end
            end
            "C": begin
               n = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           c_rec[c_count][0], c_rec[c_count][1], c_rec[c_count][2],
                           c_rec[c_count][3], c_rec[c_count][4], c_rec[c_count][5],
                           c_rec[c_count][6], c_rec[c_count][7], c_rec[c_count][8],
                           c_rec[c_count][9], c_rec[c_count][10], c_rec[c_count][11],
                           c_rec[c_count][12]);
               if (n != 13 || c_count == MAX_RECS) begin
                  $display("bad cycle record in golden file: %s", line);
                  load_ok = 1'b0;
               end else begin
                  c_count++;
               end
            end
            default: ;                             // Comment or blank line
         endcase
      end
      $fclose(fd);
   endtask

   task automatic clear_inputs();
      stall              = 1'b0;
      fetch_ready        = 1'b1;
      resolve_valid      = '0;
      resolve_mispredict = '0;
      resolve_branch     = '0;
      resolve_taken      = '0;
      resolve_pc         = '0;
      resolve_target     = '0;
      active             = 1'b0;
      exp_valid          = '0;
      exp_pc             = '0;
      exp_pred           = '0;
   endtask

   task automatic apply_record(int i);
      stall              = c_rec[i][0][0];
      fetch_ready        = c_rec[i][1][0];
      resolve_valid      = c_rec[i][2][`RESOLVE_PORTS-1:0];   // Port 0 in bit 0
      resolve_mispredict = c_rec[i][3][`RESOLVE_PORTS-1:0];
      resolve_branch     = c_rec[i][4][`RESOLVE_PORTS-1:0];
      resolve_taken      = c_rec[i][5][`RESOLVE_PORTS-1:0];
      resolve_pc[0]      = c_rec[i][6];
      resolve_target[0]  = c_rec[i][7];
      resolve_pc[1]      = c_rec[i][8];
      resolve_target[1]  = c_rec[i][9];
      exp_valid          = c_rec[i][10][`FETCH_WIDTH-1:0];
      exp_pc             = c_rec[i][11];
      exp_pred           = c_rec[i][12][`FETCH_WIDTH-1:0];
      active             = 1'b1;
   endtask

   task automatic finish_run(input bit failed);
      $display("checks %0d, errors %0d", check_count, err_count);
      if (failed || err_count != 0) begin
         $display("Finished with errors");
      end else begin
         $display("Finished with no errors");
      end
      $finish;
   endtask

   initial begin
      rst         = 1'b1;
      clear_inputs();
      m_count     = 0;
      c_count     = 0;
      cycle_limit = 0;
      load_ok     = 1'b1;
      load_golden();
      if (!load_ok || c_count == 0) begin
         $display("golden file gave no usable stimulus");
         finish_run(1'b1);
      end else begin
         cycle_limit = c_count + 20;
         repeat (4) @(posedge clk);               // Reset for 4 cycles
         #1;
         rst = 1'b0;
         for (int i = 0; i < c_count; i++) begin
            apply_record(i);                      // 1 ns after the edge
            @(posedge clk);
            #1;
         end
         clear_inputs();
         finish_run(1'b0);
      end
   end

   // Cycle counter
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   // Run limit from the record count
   initial begin
      wait (cycle_limit != 0);
      wait (cycle_count >= cycle_limit);
      $display("timeout after %0d cycles, stimulus did not complete", cycle_count);
      finish_run(1'b1);
   end

endmodule

`default_nettype wire

/* bench/golden_fetch.txt */
# M <word address> <instruction>, unmapped words read as NOP, all fields hex
# C <stall> <ready> <rvalid> <rmis> <rbranch> <rtaken> <pc0> <tgt0> <pc1> <tgt1>
#   <exp_valid> <exp_pc0> <exp_pred>, port and slot masks have port or slot 0 in bit 0
M 00000024 0dc0006f
M 00000108 0e000c63
# Sequential fetch after reset, then JAL in slot 1 jumps to 0x100
C 0 1 0 0 0 0 00000000 00000000 00000000 00000000 f 00000000 0
C 0 1 0 0 0 0 00000000 00000000 00000000 00000000 f 00000010 0
C 0 1 0 0 0 0 00000000 00000000 00000000 00000000 3 00000020 2
# Branch at 0x108 not taken, then two taken reports train it
C 0 1 0 0 0 0 00000000 00000000 00000000 00000000 f 00000100 0
C 0 1 1 0 1 1 00000108 00000000 00000000 00000000 f 00000110 0
C 0 1 1 0 1 1 00000108 00000000 00000000 00000000 f 00000120 0
C 0 1 1 1 0 0 00000130 00000100 00000000 00000000 0 00000130 0
C 0 1 0 0 0 0 00000000 00000000 00000000 00000000 7 00000100 4
# Two not-taken reports bring it back to not taken
C 0 1 1 0 1 0 00000108 00000000 00000000 00000000 f 00000200 0
C 0 1 1 0 1 0 00000108 00000000 00000000 00000000 f 00000210 0
C 0 1 1 1 0 0 00000220 00000100 00000000 00000000 0 00000220 0
C 0 1 0 0 0 0 00000000 00000000 00000000 00000000 f 00000100 0
# Both ports mispredict, port 0 wins and port 1 training is dropped
C 0 1 3 3 3 3 00000300 00000100 00000108 00000400 0 00000110 0
C 0 1 0 0 0 0 00000000 00000000 00000000 00000000 f 00000100 0
# Back-pressure and stall hold the PC, training still lands
C 0 0 1 0 1 1 00000108 00000000 00000000 00000000 0 00000110 0
C 1 1 1 0 1 1 00000108 00000000 00000000 00000000 0 00000110 0
C 1 0 0 0 0 0 00000000 00000000 00000000 00000000 0 00000110 0
C 0 1 0 0 0 0 00000000 00000000 00000000 00000000 f 00000110 0
C 0 1 1 1 0 0 00000120 00000100 00000000 00000000 0 00000120 0
C 0 1 0 0 0 0 00000000 00000000 00000000 00000000 7 00000100 4
C 0 1 0 0 0 0 00000000 00000000 00000000 00000000 f 00000200 0

/* project.f */
+incdir+hdl
hdl/fetch_pkg.sv
hdl/resolve_if.sv
hdl/resolve_arbiter.sv
hdl/imm_predecode.sv
hdl/branch_predictor.sv
hdl/pc_steer.sv
hdl/fetch_top.sv
bench/fetch_checker.sv
bench/tb_fetch_top.sv

/* Makefile */
# Verilator build and run for the fetch front end

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
FAIL_MSG  ?= Finished with errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh)
DATA    := bench/golden_fetch.txt
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

run: $(BIN) $(DATA)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status

check: run
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
